/* list.f */
+incdir+testbench
hdl/pool_pkg.sv
hdl/fp16_compare.sv
hdl/pool_window_loader.sv
hdl/pool_3x3_max.sv
hdl/pool_top.sv
testbench/tb_pool_top.sv

/* Bender.yml */
package:
  name: pool_3x3_max

sources:
  - files:
      - hdl/pool_pkg.sv
      - hdl/fp16_compare.sv
      - hdl/pool_window_loader.sv
      - hdl/pool_3x3_max.sv
      - hdl/pool_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_pool_top.sv

/* testbench/pool_stimulus.txt */
// p0 p1 p2 p3 p4 p5 p6 p7 p8 expected_max expected_invalid (binary16 hex)
// expected_max is ignored when expected_invalid is 1
4900 3C00 BC00 4000 3800 C000 4200 3E00 4400 4900 0
3C00 4900 4000 BC00 4400 3800 C000 3E00 4200 4900 0
4000 3C00 4900 4200 BC00 C000 3800 4400 3E00 4900 0
C200 3C00 4000 5640 4900 BC00 4400 3800 C000 5640 0
3800 3400 3C00 3E00 5640 4000 4200 4400 4900 5640 0
4900 4400 4200 4000 3E00 5640 3C00 3800 3400 5640 0
BC00 C000 C200 C900 D640 B800 3400 B400 C400 3400 0
C900 C200 C000 BC00 B800 B400 D640 B000 C400 B000 0
4400 4200 4000 3E00 3C00 3800 3400 4900 7BFF 7BFF 0
C000 C200 BC00 C900 D640 C400 B800 C200 B400 B400 0
5640 D640 7BFF FBFF 0001 8001 3C00 BC00 4900 7BFF 0
3C00 4000 7C00 C000 7BFF 3800 BC00 4400 FC00 7C00 0
3C00 4000 4200 C000 7BFF 3800 BC00 4400 7C00 7C00 0
FC00 FC00 FC00 FC00 FC00 FC00 FC00 FC00 FC00 FC00 0
FC00 C000 FC00 D640 FC00 FC00 C900 FC00 FC00 C000 0
FC00 FBFF FC00 FC00 FC00 FC00 FC00 FC00 FC00 FBFF 0
0001 0002 03FF 0200 0100 0010 0003 0080 0004 03FF 0
03FF 0001 0200 8001 0000 83FF 0400 0100 0010 0400 0
8001 83FF 8200 8010 8000 8100 8002 8080 8300 8000 0
0000 BC00 C000 8001 B800 C200 83FF C900 D640 0000 0
4200 4200 4200 4200 4200 4200 4200 4200 4200 4200 0
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0
8005 8005 8005 8005 8005 8005 8005 8005 8005 8005 0
7E00 3C00 4000 BC00 4400 3800 C000 3E00 4200 0000 1
3C00 4900 4000 BC00 4400 3800 C000 3E00 4200 4900 0
3C00 4000 4200 C000 7C01 3800 BC00 4400 4900 0000 1
4400 4200 4000 3E00 3C00 3800 3400 7FFF 4900 0000 1
4400 4200 4000 3E00 3C00 3800 3400 4900 FE00 0000 1
7E00 7E00 7E00 7E00 7E00 7E00 7E00 7E00 7E00 0000 1
3800 3400 3C00 3E00 5640 4000 4200 4400 4900 5640 0

/* testbench/tb_pool_checks.svh */
`ifndef TB_POOL_CHECKS_SVH
`define TB_POOL_CHECKS_SVH

int pass_count;
int fail_count;

task automatic compare_data(input string name, input logic [DATA_W-1:0] expected,
                            input logic [DATA_W-1:0] actual);
    if (actual === expected) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("[FAIL] %0t ns: %s expected %h got %h", $time, name, expected, actual);
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual === expected) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("[FAIL] %0t ns: %s expected %b got %b", $time, name, expected, actual);
    end
endtask

// Cycle counts between stream events
task automatic verify_cycles(input string name, input int expected, input int actual);
    if (actual == expected) begin
        pass_count++;
    end else begin
        fail_count++;
        $display("[FAIL] %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
    end
endtask

task automatic note_error(input string msg);
    fail_count++;
    $display("Error at %0t ns: %s", $time, msg);
endtask

`endif

/* testbench/tb_pool_top.sv */
`timescale 1ns/1ps

module tb_pool_top;
    import pool_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DLY   = 2;
    localparam int COLS        = WIN_LEN + 2;
    localparam int MAX_WIN     = 64;
    localparam int MAX_STALL   = 9 * 3 + 7;   // Pixel gaps plus longest ready stall
    localparam int EXP_LATENCY = 1 + 22;      // Handshake one cycle after the ninth pixel

    logic              clk;
    logic              rst_n;
    logic [DATA_W-1:0] pix_data;
    logic              pix_valid;
    logic              pix_ready;
    logic [DATA_W-1:0] pool_max;
    logic              pool_invalid;
    logic              pool_valid;
    logic              pool_ready;

    logic [DATA_W-1:0] win_pix [MAX_WIN][WIN_LEN];
    logic [DATA_W-1:0] win_max [MAX_WIN];
    logic              win_inv [MAX_WIN];
    int                num_win;
    bit                loaded;
    bit                stall_mode;    // Second pass, random gaps and stalls

    logic [DATA_W-1:0] exp_max_q [$];
    logic              exp_inv_q [$];
    int                results;
    int                cycle;
    int                last_xfer;
    int                pix_seen;
    int                full_at;       // Cycle right after a ninth pixel
    logic              prev_valid;
    logic              held_valid;
    logic [DATA_W-1:0] held_max;
    logic [31:0]       rng_pix;
    logic [31:0]       rng_rdy;
    sort_state_e       core_state;

    `include "tb_pool_checks.svh"

    pool_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_data     (pix_data),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .pool_max     (pool_max),
        .pool_invalid (pool_invalid),
        .pool_valid   (pool_valid),
        .pool_ready   (pool_ready)
    );

    assign core_state = UUT.u_core.state;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic load_stimulus();
        int                fd;
        int                n;
        string             line;
        logic [DATA_W-1:0] f [COLS];
        fd = $fopen("testbench/pool_stimulus.txt", "r");
        if (fd == 0) begin
            note_error("cannot open testbench/pool_stimulus.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                        f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (n == COLS && num_win < MAX_WIN) begin   // Comment lines scan nothing
                for (int i = 0; i < WIN_LEN; i++)
                    win_pix[num_win][i] = f[i];
                win_max[num_win] = f[WIN_LEN];
                win_inv[num_win] = f[WIN_LEN+1][0];
                num_win++;
            end
        end
        $fclose(fd);
        if (num_win == 0)
            note_error("no windows found in the stimulus file");
    endtask

    task automatic send_window(input int w);
        exp_max_q.push_back(win_max[w]);
        exp_inv_q.push_back(win_inv[w]);
        for (int i = 0; i < WIN_LEN; i++) begin
            rng_pix = xorshift32(rng_pix);
            if (stall_mode) begin
                pix_valid = 1'b0;
                repeat (rng_pix[1:0]) begin
                    @(posedge clk);
                    #DRIVE_DLY;
                end
            end
            pix_data  = win_pix[w][i];
            pix_valid = 1'b1;
            @(posedge clk);
            while (!pix_ready) @(posedge clk);
            #DRIVE_DLY;
            pix_valid = 1'b0;
        end
    endtask

    task automatic accept_result();
        logic [DATA_W-1:0] e_max;
        logic              e_inv;
        int                errs;
        if (exp_max_q.size() == 0) begin
            note_error("a result arrived with no window pending");
            return;
        end
        e_max = exp_max_q.pop_front();
        e_inv = exp_inv_q.pop_front();
        errs  = fail_count;
        check_flag("pool_invalid", e_inv, pool_invalid);
        if (!e_inv)
            compare_data("pool_max", e_max, pool_max);   // Value undefined with NaN
        $display("result %0d (window %0d): max %h invalid %b %s", results,
                 results % num_win, pool_max, pool_invalid,
                 (fail_count == errs) ? "ok" : "mismatch");
        results++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Output back-pressure, at most seven stalled cycles in a row
    initial begin
        int stall_run;
        stall_run  = 0;
        pool_ready = 1'b0;
        rng_rdy    = xorshift32(32'hd62b6215);
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            rng_rdy = xorshift32(rng_rdy);
            if (stall_mode && rng_rdy[2:0] < 3'd3 && stall_run < 7) begin
                pool_ready = 1'b0;
                stall_run++;
            end else begin
                pool_ready = 1'b1;
                stall_run  = 0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            prev_valid = 1'b0;
            held_valid = 1'b0;
        end else begin
            cycle++;
            if (cycle == 1) begin   // Values straight out of reset
                check_flag("pix_ready", 1'b1, pix_ready);
                check_flag("pool_valid", 1'b0, pool_valid);
            end
            if (cycle == full_at)
                check_flag("pix_ready", 1'b0, pix_ready);   // Full window blocks the stream
            if (pix_valid && pix_ready) begin
                last_xfer = cycle;
                pix_seen++;
                if (pix_seen % WIN_LEN == 0)
                    full_at = cycle + 1;
            end
            if (held_valid) begin
                check_flag("pool_valid held", 1'b1, pool_valid);
                compare_data("pool_max held", held_max, pool_max);
            end
            if (pool_valid && !prev_valid && !stall_mode)
                verify_cycles("pool_valid latency", EXP_LATENCY, cycle - last_xfer);
            if (pool_valid && pool_ready)
                accept_result();
            held_valid = pool_valid && !pool_ready;
            held_max   = pool_max;
            prev_valid = pool_valid;
        end
    end

    initial begin
        longint limit;
        wait (loaded);
        limit = longint'(2 * num_win) * (WIN_LEN + 22 + MAX_STALL) * CLK_PERIOD
              + 100 * CLK_PERIOD;
        #(limit);
        $display("Timeout after %0t ns: %0d of %0d results missing, core in %s", $time,
                 2 * num_win - results, 2 * num_win, core_state.name());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        pix_data  = '0;
        pix_valid = 1'b0;
        rng_pix   = 32'hd62b6215;
        load_stimulus();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        // One window at a time, no stalls
        for (int w = 0; w < num_win; w++) begin
            send_window(w);
            while (exp_max_q.size() != 0) begin
                @(posedge clk);
                #DRIVE_DLY;
            end
        end
        @(posedge clk);
        stall_mode = 1'b1;
        #DRIVE_DLY;
        for (int w = 0; w < num_win; w++)
            send_window(w);
        while (exp_max_q.size() != 0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        repeat (40) @(posedge clk);   // Any late extra result shows up here
        $display("Summary: %0d checks passed, %0d failed, %0d of %0d results", pass_count,
                 fail_count, results, 2 * num_win);
        if (fail_count == 0 && results == 2 * num_win && num_win > 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* hdl/pool_top.sv */
`timescale 1ns/1ps

module pool_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [pool_pkg::DATA_W-1:0] pix_data,
    input  logic                        pix_valid,
    output logic                        pix_ready,
    output logic [pool_pkg::DATA_W-1:0] pool_max,
    output logic                        pool_invalid,
    output logic                        pool_valid,
    input  logic                        pool_ready
);
    import pool_pkg::*;

    logic [WIN_W-1:0] window;
    logic             window_valid;
    logic             window_ready;

    // Fills the next window while the core sorts the current one
    pool_window_loader u_loader (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_data     (pix_data),
        .pix_valid    (pix_valid),
        .pix_ready    (pix_ready),
        .window       (window),
        .window_valid (window_valid),
        .window_ready (window_ready)
    );

    pool_3x3_max u_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .window       (window),
        .window_valid (window_valid),
        .window_ready (window_ready),
        .pool_max     (pool_max),
        .pool_invalid (pool_invalid),
        .pool_valid   (pool_valid),
        .pool_ready   (pool_ready)
    );

endmodule

/* hdl/pool_3x3_max.sv */
`timescale 1ns/1ps

module pool_3x3_max (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [pool_pkg::WIN_W-1:0]  window,
    input  logic                        window_valid,
    output logic                        window_ready,
    output logic [pool_pkg::DATA_W-1:0] pool_max,
    output logic                        pool_invalid,
    output logic                        pool_valid,
    input  logic                        pool_ready
);
    import pool_pkg::*;

    sort_state_e       state;
    logic              issued;              // Compares of this stage in flight
    logic              in_sort;

    logic [DATA_W-1:0] pix [WIN_LEN];
    logic [IDX_W-1:0]  idx [SORT_LEN];      // Permutation over pixels 0..7

    // Per-lane schedule for the current stage
    logic [IDX_W-1:0]  slot_lo [NUM_CMP];
    logic [IDX_W-1:0]  slot_hi [NUM_CMP];
    cmp_op_e           lane_op [NUM_CMP];

    logic [DATA_W-1:0] cmp_a [NUM_CMP];
    logic [DATA_W-1:0] cmp_b [NUM_CMP];
    logic [NUM_CMP-1:0] cmp_nd;
    logic [NUM_CMP-1:0] cmp_res;
    logic [NUM_CMP-1:0] cmp_inv;
    logic [NUM_CMP-1:0] cmp_rdy;

    assign window_ready = (state == S_IDLE);
    assign pool_valid   = (state == S_DONE);
    assign in_sort      = state inside {[S_BT1:S_BT7]};

    // Bitonic schedule, a true compare swaps the pair
    always_comb begin
        slot_lo = '{3'd0, 3'd2, 3'd4, 3'd6};
        slot_hi = '{3'd1, 3'd3, 3'd5, 3'd7};
        lane_op = '{CMP_GT, CMP_GT, CMP_GT, CMP_GT};
        case (state)
            S_BT1: begin
                lane_op = '{CMP_GT, CMP_LT, CMP_GT, CMP_LT};
            end
            S_BT2: begin
                slot_lo = '{3'd0, 3'd1, 3'd4, 3'd5};
                slot_hi = '{3'd2, 3'd3, 3'd6, 3'd7};
                lane_op = '{CMP_GT, CMP_GT, CMP_LT, CMP_LT};
            end
            S_BT3: begin
                lane_op = '{CMP_GT, CMP_GT, CMP_LT, CMP_LT};
            end
            S_BT4: begin
                slot_lo = '{3'd0, 3'd1, 3'd2, 3'd3};
                slot_hi = '{3'd4, 3'd5, 3'd6, 3'd7};
            end
            S_BT5: begin
                slot_lo = '{3'd0, 3'd1, 3'd4, 3'd5};
                slot_hi = '{3'd2, 3'd3, 3'd6, 3'd7};
            end
            S_BT7: begin
                slot_lo = '{3'd7, 3'd0, 3'd2, 3'd4};
            end
            default: ;  // BT6 merges neighbours ascending
        endcase
    end

    always_comb begin
        for (int l = 0; l < NUM_CMP; l++) begin
            cmp_a[l]  = pix[idx[slot_lo[l]]];
            cmp_b[l]  = pix[idx[slot_hi[l]]];
            cmp_nd[l] = in_sort && !issued && ((state != S_BT7) || (l == 0));
        end
        if (state == S_BT7)
            cmp_b[0] = pix[WIN_LEN-1];      // Ninth pixel stays out of the sort
    end

    for (genvar l = 0; l < NUM_CMP; l++) begin : g_cmp
        fp16_compare u_cmp (
            .clk     (clk),
            .rst_n   (rst_n),
            .a       (cmp_a[l]),
            .b       (cmp_b[l]),
            .op      (lane_op[l]),
            .nd      (cmp_nd[l]),
            .result  (cmp_res[l]),
            .invalid (cmp_inv[l]),
            .rdy     (cmp_rdy[l])
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            issued       <= 1'b0;
            pool_invalid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (window_valid) begin
                        state        <= S_BT1;
                        issued       <= 1'b0;
                        pool_invalid <= 1'b0;
                    end
                end
                S_DONE: begin
                    if (pool_ready)
                        state <= S_IDLE;
                end
                default: begin
                    if (!issued)
                        issued <= 1'b1;
                    if (cmp_rdy[0]) begin   // Lanes run in lockstep
                        issued <= 1'b0;
                        state  <= (state == S_BT7) ? S_DONE : sort_state_e'(state + 4'd1);
                    end
                    if (|(cmp_rdy & cmp_inv))
                        pool_invalid <= 1'b1;   // Sticky until next window
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && window_valid) begin
            for (int i = 0; i < WIN_LEN; i++)
                pix[i] <= window[i*DATA_W +: DATA_W];
            for (int i = 0; i < SORT_LEN; i++)
                idx[i] <= IDX_W'(i);
        end else if (state == S_BT7) begin
            if (cmp_rdy[0])
                pool_max <= cmp_res[0] ? cmp_a[0] : cmp_b[0];
        end else if (in_sort) begin
            for (int l = 0; l < NUM_CMP; l++) begin
                if (cmp_rdy[l] && cmp_res[l]) begin
                    idx[slot_lo[l]] <= idx[slot_hi[l]];
                    idx[slot_hi[l]] <= idx[slot_lo[l]];
                end
            end
        end
    end

    // No compare left in flight once a new window may enter
    a_ready_idle_only: assert property (@(posedge clk) disable iff (!rst_n)
        window_ready |-> !issued && (cmp_rdy == '0));

    // Result held under back-pressure
    a_max_stable: assert property (@(posedge clk) disable iff (!rst_n)
        pool_valid && !pool_ready |=> pool_valid && $stable(pool_max)
            && $stable(pool_invalid));

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        window_valid && window_ready |-> ##POOL_LAT $rose(pool_valid));

endmodule

/* hdl/pool_window_loader.sv */
`timescale 1ns/1ps

module pool_window_loader (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [pool_pkg::DATA_W-1:0] pix_data,
    input  logic                        pix_valid,
    output logic                        pix_ready,
    output logic [pool_pkg::WIN_W-1:0]  window,
    output logic                        window_valid,
    input  logic                        window_ready
);
    import pool_pkg::*;

    logic [WIN_CNT_W-1:0] count;   // Pixels held so far
    logic                 pix_xfer;
    logic                 win_xfer;

    // Full window blocks the pixel stream until handoff
    assign window_valid = (count == WIN_CNT_W'(WIN_LEN));
    assign pix_ready    = !window_valid;

    assign pix_xfer = pix_valid && pix_ready;
    assign win_xfer = window_valid && window_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            count <= '0;
        else if (win_xfer)
            count <= '0;
        else if (pix_xfer)
            count <= count + 1'b1;
    end

    // First pixel ends up in the low slot after nine shifts
    always_ff @(posedge clk) begin
        if (pix_xfer)
            window <= {pix_data, window[WIN_W-1:DATA_W]};
    end

    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= WIN_CNT_W'(WIN_LEN));

    a_window_held: assert property (@(posedge clk) disable iff (!rst_n)
        window_valid && !window_ready |=> window_valid && $stable(window));

endmodule

/* hdl/fp16_compare.sv */
`timescale 1ns/1ps

module fp16_compare (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [pool_pkg::DATA_W-1:0] a,
    input  logic [pool_pkg::DATA_W-1:0] b,
    input  pool_pkg::cmp_op_e           op,
    input  logic                        nd,
    output logic                        result,
    output logic                        invalid,
    output logic                        rdy
);
    import pool_pkg::*;

    // Stage one registers
    logic              s1_valid;
    cmp_op_e           s1_op;
    logic [DATA_W-1:0] s1_key_a;
    logic [DATA_W-1:0] s1_key_b;
    logic              s1_unord;

    logic              key_lt;
    logic              key_eq;
    logic              key_gt;
    logic              rel;

    function automatic logic is_nan(input logic [DATA_W-1:0] x);
        return (x[14:10] == 5'h1f) && (x[9:0] != 10'd0);
    endfunction

    // Maps binary16 onto an unsigned order, both zeros to one key
    function automatic logic [DATA_W-1:0] order_key(input logic [DATA_W-1:0] x);
        logic [DATA_W-1:0] key;
        if (x[14:0] == 15'd0)
            key = {1'b1, 15'd0};
        else if (x[15])
            key = {1'b0, ~x[14:0]};
        else
            key = {1'b1, x[14:0]};
        return key;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= nd;
    end

    always_ff @(posedge clk) begin
        s1_op    <= op;
        s1_key_a <= order_key(a);
        s1_key_b <= order_key(b);
        s1_unord <= is_nan(a) || is_nan(b);
    end

    assign key_lt = s1_key_a < s1_key_b;
    assign key_eq = s1_key_a == s1_key_b;
    assign key_gt = s1_key_a > s1_key_b;

    always_comb begin
        case (s1_op)
            CMP_UNORDERED: rel = s1_unord;
            CMP_LT:        rel = !s1_unord && key_lt;
            CMP_EQ:        rel = !s1_unord && key_eq;
            CMP_LE:        rel = !s1_unord && (key_lt || key_eq);
            CMP_GT:        rel = !s1_unord && key_gt;
            CMP_NE:        rel = s1_unord || !key_eq;   // NaN is never equal
            CMP_GE:        rel = !s1_unord && (key_gt || key_eq);
            default:       rel = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rdy <= 1'b0;
        else
            rdy <= s1_valid;
    end

    always_ff @(posedge clk) begin
        result  <= rel;
        invalid <= s1_unord;
    end

    // Fixed latency both ways
    a_nd_to_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        nd |-> ##CMP_LAT rdy);
    a_rdy_from_nd: assert property (@(posedge clk) disable iff (!rst_n)
        rdy |-> $past(nd, CMP_LAT));

endmodule

/* hdl/pool_pkg.sv */
package pool_pkg;

    // Pixel and window geometry
    localparam int unsigned DATA_W    = 16;               // binary16
    localparam int unsigned WIN_LEN   = 9;
    localparam int unsigned WIN_W     = DATA_W * WIN_LEN;
    localparam int unsigned WIN_CNT_W = $clog2(WIN_LEN + 1);

    // Bitonic network over the first eight pixels
    localparam int unsigned SORT_LEN  = 8;
    localparam int unsigned IDX_W     = $clog2(SORT_LEN);
    localparam int unsigned NUM_CMP   = 4;

    // Comparator latency, nd to rdy
    localparam int unsigned CMP_LAT   = 2;

    // Seven stages of issue plus wait, then one cycle into S_DONE
    localparam int unsigned POOL_LAT  = 7 * (CMP_LAT + 1) + 1;

    typedef enum logic [5:0] {
        CMP_UNORDERED = 6'b000100,
        CMP_LT        = 6'b001100,
        CMP_EQ        = 6'b010100,
        CMP_LE        = 6'b011100,
        CMP_GT        = 6'b100100,
        CMP_NE        = 6'b101100,
        CMP_GE        = 6'b110100
    } cmp_op_e;

    typedef enum logic [3:0] {
        S_IDLE = 4'd0,
        S_BT1  = 4'd1,
        S_BT2  = 4'd2,
        S_BT3  = 4'd3,
        S_BT4  = 4'd4,
        S_BT5  = 4'd5,
        S_BT6  = 4'd6,
        S_BT7  = 4'd7,   // Largest of eight against pixel 8
        S_DONE = 4'd8
    } sort_state_e;

endpackage
